// File: logic/ex_mem_pkg.sv
package ex_mem_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_AW     = 5;
    localparam int SIZE_W     = 3;
    localparam int ALU_OP_W   = 4;

    // Data memory is byte addressed
    localparam int DMEM_BYTES = 1024;
    localparam int DMEM_AW    = $clog2(DMEM_BYTES);

    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [REG_AW-1:0]   reg_addr_t;
    typedef logic [SIZE_W-1:0]   word_size_t;
    typedef logic [ALU_OP_W-1:0] alu_op_t;
    typedef logic [DMEM_AW-1:0]  mem_addr_t;

    // ALU operations
    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_NOR = 4'd5;
    localparam alu_op_t ALU_SLT = 4'd6;  // Signed compare
    localparam alu_op_t ALU_SLL = 4'd7;
    localparam alu_op_t ALU_SRL = 4'd8;
    localparam alu_op_t ALU_SRA = 4'd9;
    localparam alu_op_t ALU_LUI = 4'd10; // Operand B into the upper half

    // Memory access sizes, zero means no valid access
    localparam word_size_t SIZE_BYTE = 3'd1;
    localparam word_size_t SIZE_HALF = 3'd2;
    localparam word_size_t SIZE_WORD = 3'd3;

endpackage

// File: logic/alu.sv
`timescale 1ns/10ps

module alu
    import ex_mem_pkg::*;
(
    input  data_t   i_alu_a,
    input  data_t   i_alu_b,
    input  alu_op_t i_alu_op,
    output data_t   o_result,
    output logic    o_cero
);

    logic [4:0] shamt;

    assign shamt = i_alu_b[4:0]; // Only the low five bits count for shifts

    always_comb begin
        case (i_alu_op)
            ALU_ADD: begin
                o_result = i_alu_a + i_alu_b;
            end
            ALU_SUB: begin
                o_result = i_alu_a - i_alu_b;
            end
            ALU_AND: begin
                o_result = i_alu_a & i_alu_b;
            end
            ALU_OR: begin
                o_result = i_alu_a | i_alu_b;
            end
            ALU_XOR: begin
                o_result = i_alu_a ^ i_alu_b;
            end
            ALU_NOR: begin
                o_result = ~(i_alu_a | i_alu_b);
            end
            ALU_SLT: begin
                o_result = ($signed(i_alu_a) < $signed(i_alu_b)) ? 32'd1 : 32'd0;
            end
            ALU_SLL: begin
                o_result = i_alu_a << shamt;
            end
            ALU_SRL: begin
                o_result = i_alu_a >> shamt;
            end
            ALU_SRA: begin
                o_result = $signed(i_alu_a) >>> shamt; // Sign bit fills from the top
            end
            ALU_LUI: begin
                o_result = i_alu_b << 16;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

    // Used by beq, which subtracts the two operands
    assign o_cero = (o_result == '0);

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/10ps

module execute_stage
    import ex_mem_pkg::*;
(
    input  data_t     i_pc_plus4,
    input  data_t     i_data_a,
    input  data_t     i_data_b,
    input  data_t     i_imm,
    input  alu_op_t   i_alu_op,
    input  logic      i_alu_src,
    input  logic      i_reg_dst,
    input  reg_addr_t i_rt,
    input  reg_addr_t i_rd,

    output data_t     o_alu_result,
    output data_t     o_branch_addr,
    output logic      o_cero,
    output reg_addr_t o_reg_dir_to_write
);

    data_t alu_b;

    // Immediate for I-type, register operand for R-type
    assign alu_b = i_alu_src ? i_imm : i_data_b;

    alu u_alu (
        .i_alu_a  (i_data_a),
        .i_alu_b  (alu_b),
        .i_alu_op (i_alu_op),
        .o_result (o_alu_result),
        .o_cero   (o_cero)
    );

    // The immediate counts words, so it is scaled to bytes
    assign o_branch_addr = i_pc_plus4 + (i_imm << 2);

    assign o_reg_dir_to_write = i_reg_dst ? i_rd : i_rt; // rd for R-type, rt otherwise

endmodule

// File: logic/ex_mem.sv
`timescale 1ns/10ps

module ex_mem
    import ex_mem_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_step,
    input  logic       i_flush,
    input  logic       i_cero,
    input  logic       i_branch,
    input  data_t      i_alu_result,
    input  data_t      i_branch_addr,
    input  data_t      i_data_b_to_write,
    input  logic       i_mem_read,
    input  logic       i_mem_write,
    input  logic       i_reg_write,
    input  logic       i_mem_to_reg,
    input  logic       i_signed,
    input  reg_addr_t  i_reg_dir_to_write,
    input  word_size_t i_word_size,

    output logic       o_cero,
    output data_t      o_alu_result,
    output data_t      o_data_b_to_write,
    output logic       o_mem_read,
    output logic       o_mem_write,
    output logic       o_mem_to_reg,
    output logic       o_signed,
    output logic       o_reg_write,
    output reg_addr_t  o_reg_dir_to_write,
    output word_size_t o_word_size,
    output logic       o_branch,
    output data_t      o_branch_addr
);

    // Captures on the falling edge so the memory stage has the rising edge to write
    always_ff @(negedge i_clk) begin
        if (i_reset) begin
            o_cero             <= 1'b0;
            o_alu_result       <= '0;
            o_data_b_to_write  <= '0;
            o_mem_read         <= 1'b0;
            o_mem_write        <= 1'b0;
            o_mem_to_reg       <= 1'b0;
            o_signed           <= 1'b0;
            o_reg_write        <= 1'b0;
            o_reg_dir_to_write <= '0;
            o_word_size        <= '0;
            o_branch           <= 1'b0;
            o_branch_addr      <= '0;
        end else if (i_flush || i_step) begin
            o_alu_result       <= i_alu_result;
            o_data_b_to_write  <= i_data_b_to_write;
            o_reg_dir_to_write <= i_reg_dir_to_write;
            o_branch_addr      <= i_branch_addr;
            // A flush turns the instruction into a bubble but keeps its payload
            o_cero             <= i_flush ? 1'b0 : i_cero;
            o_mem_read         <= i_flush ? 1'b0 : i_mem_read;
            o_mem_write        <= i_flush ? 1'b0 : i_mem_write;
            o_mem_to_reg       <= i_flush ? 1'b0 : i_mem_to_reg;
            o_signed           <= i_flush ? 1'b0 : i_signed;
            o_reg_write        <= i_flush ? 1'b0 : i_reg_write;
            o_word_size        <= i_flush ? '0 : i_word_size;
            o_branch           <= i_flush ? 1'b0 : i_branch;
        end
    end

    // Decode upstream must never issue a load and a store in one instruction
    a_no_read_and_write: assert property (
        @(posedge i_clk) disable iff (i_reset) !(o_mem_read && o_mem_write));

    a_reset_clears_ctrl: assert property (
        @(negedge i_clk) i_reset |=> !(o_cero || o_mem_read || o_mem_write ||
                                      o_mem_to_reg || o_reg_write || o_branch));

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/10ps

module mem_stage
    import ex_mem_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_step,
    input  logic       i_cero,
    input  logic       i_branch,
    input  data_t      i_alu_result,
    input  data_t      i_data_b_to_write,
    input  logic       i_mem_read,
    input  logic       i_mem_write,
    input  logic       i_mem_to_reg,
    input  logic       i_signed,
    input  word_size_t i_word_size,
    input  logic       i_reg_write,
    input  reg_addr_t  i_reg_dir_to_write,
    input  mem_addr_t  i_dbg_addr,

    output logic       o_pc_src,
    output data_t      o_wb_data,
    output logic       o_reg_write,
    output reg_addr_t  o_wb_reg,
    output data_t      o_dbg_data
);

    logic [7:0] dmem [DMEM_BYTES];

    mem_addr_t addr0;
    mem_addr_t addr1;
    mem_addr_t addr2;
    mem_addr_t addr3;
    mem_addr_t dbg_base;
    data_t     load_word;
    data_t     load_data;

    assign addr0 = i_alu_result[DMEM_AW-1:0];
    assign addr1 = addr0 + mem_addr_t'(1);
    assign addr2 = addr0 + mem_addr_t'(2);
    assign addr3 = addr0 + mem_addr_t'(3);

    // Stores take their bytes from the low end of data_b, little-endian
    always_ff @(posedge i_clk) begin
        if (i_step && i_mem_write) begin
            case (i_word_size)
                SIZE_BYTE: begin
                    dmem[addr0] <= i_data_b_to_write[7:0];
                end
                SIZE_HALF: begin
                    dmem[addr0] <= i_data_b_to_write[7:0];
                    dmem[addr1] <= i_data_b_to_write[15:8];
                end
                SIZE_WORD: begin
                    dmem[addr0] <= i_data_b_to_write[7:0];
                    dmem[addr1] <= i_data_b_to_write[15:8];
                    dmem[addr2] <= i_data_b_to_write[23:16];
                    dmem[addr3] <= i_data_b_to_write[31:24];
                end
                default: begin
                end
            endcase
        end
    end

    assign load_word = {dmem[addr3], dmem[addr2], dmem[addr1], dmem[addr0]};

    always_comb begin
        case (i_word_size)
            SIZE_BYTE: begin
                load_data = i_signed ? {{24{load_word[7]}}, load_word[7:0]}
                                     : {24'b0, load_word[7:0]};
            end
            SIZE_HALF: begin
                load_data = i_signed ? {{16{load_word[15]}}, load_word[15:0]}
                                     : {16'b0, load_word[15:0]};
            end
            default: begin
                load_data = load_word; // Full word needs no extension
            end
        endcase
    end

    assign o_wb_data   = i_mem_to_reg ? load_data : i_alu_result;
    assign o_pc_src    = i_branch && i_cero;      // beq taken
    assign o_reg_write = i_reg_write;
    assign o_wb_reg    = i_reg_dir_to_write;

    // The debugger always sees the whole aligned word
    assign dbg_base   = {i_dbg_addr[DMEM_AW-1:2], 2'b00};
    assign o_dbg_data = {dmem[dbg_base + mem_addr_t'(3)], dmem[dbg_base + mem_addr_t'(2)],
                         dmem[dbg_base + mem_addr_t'(1)], dmem[dbg_base]};

    a_access_aligned: assert property (
        @(posedge i_clk) (i_mem_read || i_mem_write) |->
            !((i_word_size == SIZE_HALF) && i_alu_result[0]) &&
            !((i_word_size == SIZE_WORD) && (i_alu_result[1:0] != 2'b00)));

endmodule

// File: logic/ex_mem_top.sv
`timescale 1ns/10ps

module ex_mem_top
    import ex_mem_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_step,
    input  logic       i_flush,

    input  data_t      i_pc_plus4,
    input  data_t      i_data_a,
    input  data_t      i_data_b,
    input  data_t      i_imm,
    input  alu_op_t    i_alu_op,
    input  logic       i_alu_src,
    input  logic       i_reg_dst,
    input  reg_addr_t  i_rt,
    input  reg_addr_t  i_rd,

    input  logic       i_branch,
    input  logic       i_mem_read,
    input  logic       i_mem_write,
    input  logic       i_reg_write,
    input  logic       i_mem_to_reg,
    input  logic       i_signed,
    input  word_size_t i_word_size,

    input  mem_addr_t  i_dbg_addr,

    output logic       o_pc_src,
    output data_t      o_branch_addr,
    output data_t      o_wb_data,
    output logic       o_reg_write,
    output reg_addr_t  o_wb_reg,
    output data_t      o_dbg_data
);

    data_t      ex_alu_result;
    data_t      ex_branch_addr;
    logic       ex_cero;
    reg_addr_t  ex_reg_dir;

    logic       mem_cero;
    data_t      mem_alu_result;
    data_t      mem_data_b;
    logic       mem_read;
    logic       mem_write;
    logic       mem_to_reg;
    logic       mem_signed;
    logic       mem_reg_write;
    reg_addr_t  mem_reg_dir;
    word_size_t mem_word_size;
    logic       mem_branch;

    execute_stage u_execute_stage (
        .i_pc_plus4         (i_pc_plus4),
        .i_data_a           (i_data_a),
        .i_data_b           (i_data_b),
        .i_imm              (i_imm),
        .i_alu_op           (i_alu_op),
        .i_alu_src          (i_alu_src),
        .i_reg_dst          (i_reg_dst),
        .i_rt               (i_rt),
        .i_rd               (i_rd),
        .o_alu_result       (ex_alu_result),
        .o_branch_addr      (ex_branch_addr),
        .o_cero             (ex_cero),
        .o_reg_dir_to_write (ex_reg_dir)
    );

    // Register B is the store data
    ex_mem u_ex_mem (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_step             (i_step),
        .i_flush            (i_flush),
        .i_cero             (ex_cero),
        .i_branch           (i_branch),
        .i_alu_result       (ex_alu_result),
        .i_branch_addr      (ex_branch_addr),
        .i_data_b_to_write  (i_data_b),
        .i_mem_read         (i_mem_read),
        .i_mem_write        (i_mem_write),
        .i_reg_write        (i_reg_write),
        .i_mem_to_reg       (i_mem_to_reg),
        .i_signed           (i_signed),
        .i_reg_dir_to_write (ex_reg_dir),
        .i_word_size        (i_word_size),
        .o_cero             (mem_cero),
        .o_alu_result       (mem_alu_result),
        .o_data_b_to_write  (mem_data_b),
        .o_mem_read         (mem_read),
        .o_mem_write        (mem_write),
        .o_mem_to_reg       (mem_to_reg),
        .o_signed           (mem_signed),
        .o_reg_write        (mem_reg_write),
        .o_reg_dir_to_write (mem_reg_dir),
        .o_word_size        (mem_word_size),
        .o_branch           (mem_branch),
        .o_branch_addr      (o_branch_addr)
    );

    mem_stage u_mem_stage (
        .i_clk              (i_clk),
        .i_step             (i_step),
        .i_cero             (mem_cero),
        .i_branch           (mem_branch),
        .i_alu_result       (mem_alu_result),
        .i_data_b_to_write  (mem_data_b),
        .i_mem_read         (mem_read),
        .i_mem_write        (mem_write),
        .i_mem_to_reg       (mem_to_reg),
        .i_signed           (mem_signed),
        .i_word_size        (mem_word_size),
        .i_reg_write        (mem_reg_write),
        .i_reg_dir_to_write (mem_reg_dir),
        .i_dbg_addr         (i_dbg_addr),
        .o_pc_src           (o_pc_src),
        .o_wb_data          (o_wb_data),
        .o_reg_write        (o_reg_write),
        .o_wb_reg           (o_wb_reg),
        .o_dbg_data         (o_dbg_data)
    );

endmodule

// File: tests/tb_ex_mem_top.sv
`timescale 1ns/10ps

module tb_ex_mem_top
    import ex_mem_pkg::*;
();

    logic       i_clk;
    logic       i_reset;
    logic       i_step;
    logic       i_flush;
    data_t      i_pc_plus4;
    data_t      i_data_a;
    data_t      i_data_b;
    data_t      i_imm;
    alu_op_t    i_alu_op;
    logic       i_alu_src;
    logic       i_reg_dst;
    reg_addr_t  i_rt;
    reg_addr_t  i_rd;
    logic       i_branch;
    logic       i_mem_read;
    logic       i_mem_write;
    logic       i_reg_write;
    logic       i_mem_to_reg;
    logic       i_signed;
    word_size_t i_word_size;
    mem_addr_t  i_dbg_addr;
    logic       o_pc_src;
    data_t      o_branch_addr;
    data_t      o_wb_data;
    logic       o_reg_write;
    reg_addr_t  o_wb_reg;
    data_t      o_dbg_data;

    logic [7:0] mem_model [DMEM_BYTES]; // Expected contents of the data memory
    string      test_name;

    ex_mem_top u_ex_mem_top (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    initial begin
        #1_000_000;
        $display("ERROR: the simulation ran past its time limit");
        abort_run();
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(string what, data_t expected, data_t actual);
        if (actual !== expected) begin
            $display("ERROR: %s %s expected %h actual %h", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_reg(string what, reg_addr_t expected, reg_addr_t actual);
        if (actual !== expected) begin
            $display("ERROR: %s %s expected %0d actual %0d", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(string what, logic expected, logic actual);
        if (actual !== expected) begin
            $display("ERROR: %s %s expected %b actual %b", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    function automatic data_t alu_model(alu_op_t op, data_t a, data_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_NOR: return ~(a | b);
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SRA: return data_t'($signed(a) >>> b[4:0]);
            ALU_LUI: return {b[15:0], 16'h0000};
            default: return '0;
        endcase
    endfunction

    function automatic data_t word_model(mem_addr_t addr);
        mem_addr_t base;
        base = {addr[DMEM_AW-1:2], 2'b00};
        return {mem_model[base + 3], mem_model[base + 2], mem_model[base + 1], mem_model[base]};
    endfunction

    function automatic data_t load_model(mem_addr_t addr, word_size_t size, logic sgn);
        case (size)
            SIZE_BYTE: return {{24{sgn & mem_model[addr][7]}}, mem_model[addr]};
            SIZE_HALF: return {{16{sgn & mem_model[addr + 1][7]}}, mem_model[addr + 1],
                               mem_model[addr]};
            default:   return word_model(addr);
        endcase
    endfunction

    function automatic mem_addr_t align_addr(mem_addr_t addr, word_size_t size);
        if (size == SIZE_HALF) return {addr[DMEM_AW-1:1], 1'b0};
        if (size == SIZE_WORD) return {addr[DMEM_AW-1:2], 2'b00};
        return addr;
    endfunction

    task automatic update_model(mem_addr_t addr, data_t value, word_size_t size);
        int bytes;
        bytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
        for (int k = 0; k < bytes; k++) mem_model[addr + k] = value[8*k +: 8];
    endtask

    // An idle instruction: add with no memory access and no write-back
    task automatic drive_idle();
        i_pc_plus4   <= '0;
        i_data_a     <= '0;
        i_data_b     <= '0;
        i_imm        <= '0;
        i_alu_op     <= ALU_ADD;
        i_alu_src    <= 1'b0;
        i_reg_dst    <= 1'b0;
        i_rt         <= '0;
        i_rd         <= '0;
        i_branch     <= 1'b0;
        i_mem_read   <= 1'b0;
        i_mem_write  <= 1'b0;
        i_reg_write  <= 1'b0;
        i_mem_to_reg <= 1'b0;
        i_signed     <= 1'b0;
        i_word_size  <= '0;
        i_step       <= 1'b1;
        i_flush      <= 1'b0;
    endtask

    task automatic drive_store(mem_addr_t addr, data_t value, word_size_t size);
        drive_idle();
        i_data_a    <= data_t'(addr); // Address is base plus a zero immediate
        i_alu_src   <= 1'b1;
        i_data_b    <= value;
        i_mem_write <= 1'b1;
        i_word_size <= size;
    endtask

    // Outputs settle half a cycle after the drive edge
    task automatic wait_capture();
        @(negedge i_clk);
        #1;
    endtask

    task automatic wait_dbg_word(mem_addr_t addr, data_t expected);
        int cycles;
        cycles = 0;
        @(posedge i_clk);
        i_dbg_addr <= addr;
        wait_capture();
        while (o_dbg_data !== expected && cycles < 8) begin
            wait_capture();
            cycles++;
        end
        if (o_dbg_data !== expected) begin
            $display("ERROR: %s timed out waiting for the debug word at %h", test_name, addr);
            check_data("debug word", expected, o_dbg_data);
        end
    endtask

    task automatic do_store(mem_addr_t addr, data_t value, word_size_t size);
        @(posedge i_clk);
        drive_store(addr, value, size);
        wait_capture();
        update_model(addr, value, size);
        wait_dbg_word(addr, word_model(addr));
    endtask

    task automatic do_load(mem_addr_t addr, word_size_t size, logic sgn);
        @(posedge i_clk);
        drive_idle();
        i_data_a     <= data_t'(addr);
        i_alu_src    <= 1'b1;
        i_mem_read   <= 1'b1;
        i_mem_to_reg <= 1'b1;
        i_reg_write  <= 1'b1;
        i_word_size  <= size;
        i_signed     <= sgn;
        wait_capture();
        check_data("load data", load_model(addr, size, sgn), o_wb_data);
        check_bit("load reg write", 1'b1, o_reg_write);
    endtask

    task automatic issue_beq(data_t pc, data_t imm, data_t a, data_t b, logic br);
        @(posedge i_clk);
        drive_idle();
        i_pc_plus4 <= pc;
        i_imm      <= imm;
        i_data_a   <= a;
        i_data_b   <= b;
        i_alu_op   <= ALU_SUB;
        i_branch   <= br;
        wait_capture();
    endtask

    task automatic test_reset();
        test_name = "test_reset";
        wait_capture();
        check_bit("reg write", 1'b0, o_reg_write);
        check_bit("pc src", 1'b0, o_pc_src);
        check_data("wb data", '0, o_wb_data);
        check_data("branch addr", '0, o_branch_addr);
    endtask

    task automatic test_alu_random();
        alu_op_t   op;
        data_t     a;
        data_t     b;
        data_t     imm;
        logic      reg_dst;
        logic      wr;
        reg_addr_t rt;
        reg_addr_t rd;
        test_name = "test_alu_random";
        for (int n = 0; n < 40; n++) begin
            op      = alu_op_t'($urandom_range(0, 11)); // 11 is an unused opcode
            a       = $urandom;
            b       = $urandom;
            imm     = $urandom;
            reg_dst = $urandom_range(0, 1);
            wr      = $urandom_range(0, 1);
            rt      = reg_addr_t'($urandom);
            rd      = reg_addr_t'($urandom);
            @(posedge i_clk);
            drive_idle();
            i_alu_op    <= op;
            i_data_a    <= a;
            i_data_b    <= b;
            i_imm       <= imm;
            i_alu_src   <= n[0];
            i_reg_dst   <= reg_dst;
            i_rt        <= rt;
            i_rd        <= rd;
            i_reg_write <= wr;
            wait_capture();
            check_data("alu result", alu_model(op, a, n[0] ? imm : b), o_wb_data);
            check_reg("wb reg", reg_dst ? rd : rt, o_wb_reg);
            check_bit("reg write", wr, o_reg_write);
        end
    endtask

    task automatic test_store_load();
        word_size_t size;
        mem_addr_t  addr;
        test_name = "test_store_load";
        // Whole words first so no byte of the region is left unknown
        for (int k = 0; k < 8; k++) do_store(mem_addr_t'('h40 + 4 * k), $urandom, SIZE_WORD);
        for (int k = 0; k < 6; k++) begin
            size = word_size_t'($urandom_range(1, 3));
            addr = align_addr(mem_addr_t'('h40 + $urandom_range(0, 31)), size);
            do_store(addr, $urandom, size);
        end
        do_store('h41, 32'h1234_5680, SIZE_BYTE);
        do_store('h46, 32'hABCD_8001, SIZE_HALF);
        do_store('h4A, 32'h0000_7FFE, SIZE_HALF);
        do_load('h41, SIZE_BYTE, 1'b1);
        do_load('h41, SIZE_BYTE, 1'b0);
        do_load('h46, SIZE_HALF, 1'b1);
        do_load('h46, SIZE_HALF, 1'b0);
        do_load('h4A, SIZE_HALF, 1'b1);
        do_load('h44, SIZE_WORD, 1'b0);
        for (int k = 0; k < 8; k++) begin
            size = word_size_t'($urandom_range(1, 3));
            addr = align_addr(mem_addr_t'('h40 + $urandom_range(0, 31)), size);
            do_load(addr, size, $urandom_range(0, 1));
        end
    endtask

    task automatic test_branch();
        data_t pc;
        data_t imm;
        data_t a;
        test_name = "test_branch";
        pc  = $urandom & 32'hFFFF_FFFC;
        imm = $urandom;
        a   = $urandom;
        issue_beq(pc, imm, a, a, 1'b1);
        check_bit("taken", 1'b1, o_pc_src);
        check_data("target", pc + imm * 4, o_branch_addr);
        issue_beq(pc, imm, a, a + 1, 1'b1);
        check_bit("not equal", 1'b0, o_pc_src);
        issue_beq(pc, imm, a, a, 1'b0); // Zero result but no branch
        check_bit("no branch", 1'b0, o_pc_src);
    endtask

    task automatic test_step_hold();
        test_name = "test_step_hold";
        do_store('h60, 32'hCAFE_F00D, SIZE_WORD);
        @(posedge i_clk);
        drive_idle();
        i_data_a    <= 32'd100;
        i_data_b    <= 32'd23;
        i_rt        <= 5'd5;
        i_reg_write <= 1'b1;
        wait_capture();
        check_data("alu result", 32'd123, o_wb_data);
        @(posedge i_clk);
        drive_store('h60, 32'h1234_5678, SIZE_WORD);
        i_rt   <= 5'd7;
        i_step <= 1'b0;
        repeat (3) wait_capture();
        check_data("held wb data", 32'd123, o_wb_data);
        check_reg("held wb reg", 5'd5, o_wb_reg);
        check_bit("held reg write", 1'b1, o_reg_write);
        wait_dbg_word('h60, word_model('h60));
        @(posedge i_clk);
        i_step <= 1'b1;
        wait_capture();
        check_data("stepped wb data", 32'h60, o_wb_data);
        check_reg("stepped wb reg", 5'd7, o_wb_reg);
        update_model('h60, 32'h1234_5678, SIZE_WORD);
        wait_dbg_word('h60, word_model('h60));
    endtask

    task automatic test_flush();
        test_name = "test_flush";
        do_store('h64, 32'h0BAD_CAFE, SIZE_WORD);
        @(posedge i_clk);
        drive_idle(); // Register holds a zero ALU result before the flushed store
        wait_capture();
        @(posedge i_clk);
        drive_store('h64, 32'hDEAD_BEEF, SIZE_WORD);
        i_reg_write <= 1'b1;
        i_rt        <= 5'd9;
        i_branch    <= 1'b1;
        i_flush     <= 1'b1;
        wait_capture();
        check_bit("reg write", 1'b0, o_reg_write);
        check_bit("pc src", 1'b0, o_pc_src);
        check_data("wb data", 32'h64, o_wb_data);
        check_reg("wb reg", 5'd9, o_wb_reg);
        repeat (2) wait_capture();
        wait_dbg_word('h64, word_model('h64));
        // A beq with equal operands that is flushed must not be taken
        @(posedge i_clk);
        drive_idle();
        i_pc_plus4 <= 32'h100;
        i_data_a   <= 32'd77;
        i_data_b   <= 32'd77;
        i_alu_op   <= ALU_SUB;
        i_branch   <= 1'b1;
        i_flush    <= 1'b1;
        wait_capture();
        check_bit("flushed beq", 1'b0, o_pc_src);
        check_data("flushed target", 32'h100, o_branch_addr);
        @(posedge i_clk);
        drive_idle();
    endtask

    initial begin
        void'($urandom(32'h2d3302b4));
        i_reset = 1'b1;
        drive_idle();
        i_step     <= 1'b0;
        i_dbg_addr <= '0;
        repeat (5) @(posedge i_clk);
        i_reset <= 1'b0;
        test_reset();
        test_alu_random();
        test_store_load();
        test_branch();
        test_step_hold();
        test_flush();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: sim.f
logic/ex_mem_pkg.sv
logic/alu.sv
logic/execute_stage.sv
logic/ex_mem.sv
logic/mem_stage.sv
logic/ex_mem_top.sv
tests/tb_ex_mem_top.sv

// File: Bender.yml
package:
  name: ex_mem

sources:
  - logic/ex_mem_pkg.sv
  - logic/alu.sv
  - logic/execute_stage.sv
  - logic/ex_mem.sv
  - logic/mem_stage.sv
  - logic/ex_mem_top.sv
  - target: test
    files:
      - tests/tb_ex_mem_top.sv
